// File: build.f
+incdir+include
rtl/eu_reg_pkg.sv
rtl/eu_core_pkg.sv
rtl/eu_ifs.sv
rtl/eu_bus_decoder.sv
rtl/eu_core_slice.sv
rtl/eu_read_mux.sv
rtl/event_unit.sv
test/eu_props.sv
test/tb_event_unit.sv

// File: Makefile
TOP := tb_event_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: test/tb_event_unit.sv
//**************************************************************************
// clock, reset, random and directed stimulus for the event unit
// reference model with per-cycle output comparison and a cycle watchdog
//**************************************************************************

`timescale 1ns/10ps

`include "eu_macros.svh"

module tb_event_unit
  import eu_reg_pkg::*;
  import eu_core_pkg::*;
();

  localparam int NB         = `EU_NB_CORES;
  localparam int MODE_MASK  = 0;
  localparam int MODE_BUF   = 1;
  localparam int MODE_TRIG  = 2;
  localparam int N_MASK     = 300;
  localparam int N_BUF      = 400;
  localparam int N_TRIG     = 300;
  localparam int N_IRQ      = 200;
  // upper bound for one core's sleep sequence
  localparam int N_SLEEP    = 24;
  localparam int RUN_CYCLES = 16 + N_MASK + N_BUF + N_TRIG + NB + N_IRQ + 1
                            + NB * N_SLEEP + 4;
  localparam int TIMEOUT    = 2 * RUN_CYCLES;

  typedef struct packed {
    event_vec_t evt_mask;
    event_vec_t irq_mask;
    event_vec_t buffer;
    logic       sleep;
    logic       irq_req;
  } core_model_t;

  logic          clk_i;
  logic          rst_ni;
  logic          req_i;
  logic          we_i;
  eu_addr_t      addr_i;
  event_vec_t    wdata_i;
  logic          gnt_o;
  logic          rvalid_o;
  event_vec_t    rdata_o;
  event_vec_t    event_lines_i [NB];
  logic [NB-1:0] irq_ack_i;
  irq_id_t       irq_ack_id_i  [NB];
  logic [NB-1:0] wait_req_i;
  logic [NB-1:0] wait_clear_i;
  logic [NB-1:0] irq_req_o;
  irq_id_t       irq_id_o      [NB];
  logic [NB-1:0] wake_o;
  logic [NB-1:0] clock_en_o;

  core_model_t   mdl [NB];
  logic          exp_rvalid;
  event_vec_t    exp_rdata;
  logic [31:0]   rng_state;
  int            checks = 0;
  int            errors = 0;
  int            cycle_cnt = 0;

  event_unit event_unit_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .gnt_o         (gnt_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .event_lines_i (event_lines_i),
    .irq_ack_i     (irq_ack_i),
    .irq_ack_id_i  (irq_ack_id_i),
    .wait_req_i    (wait_req_i),
    .wait_clear_i  (wait_clear_i),
    .irq_req_o     (irq_req_o),
    .irq_id_o      (irq_id_o),
    .wake_o        (wake_o),
    .clock_en_o    (clock_en_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // highest set bit searched from the top down
  function automatic irq_id_t top_index(input event_vec_t v);
    for (int i = `EU_EVT_W - 1; i >= 0; i--) begin
      if (v[i]) begin
        return irq_id_t'(i);
      end
    end
    return '0;
  endfunction

  function automatic event_vec_t ref_read(input core_model_t s, input eu_reg_e off);
    case (off)
      EVT_MASK:          return s.evt_mask;
      IRQ_MASK:          return s.irq_mask;
      CLOCK_STATUS:      return {{(`EU_EVT_W - 1){1'b0}}, ~s.sleep};
      BUFFER:            return s.buffer;
      BUFFER_MASKED:     return s.buffer & s.evt_mask;
      BUFFER_IRQ_MASKED: return s.buffer & s.irq_mask;
      default:           return '0;
    endcase
  endfunction

  // next state of core c from the inputs seen at this edge
  function automatic core_model_t ref_core(input core_model_t s, input int c);
    core_model_t n;
    event_vec_t  masked;
    event_vec_t  imasked;
    event_vec_t  clr;
    event_vec_t  sw;
    logic        trig;
    logic        wr;
    logic [NB-1:0] tgt;
    n       = s;
    masked  = s.buffer & s.evt_mask;
    imasked = s.buffer & s.irq_mask;
    trig    = req_i && we_i && (addr_i.reg_off == SW_TRIGGER);
    wr      = req_i && we_i && !trig && (addr_i.core == core_idx_t'(c));
    tgt     = wdata_i[19:16];
    if (tgt == '0) begin
      tgt = '1;
    end
    sw  = (trig && tgt[c]) ? {24'h0, wdata_i[7:0]} : '0;
    clr = '0;
    if (wr) begin
      case (addr_i.reg_off)
        EVT_MASK:     n.evt_mask = wdata_i;
        EVT_MASK_AND: n.evt_mask = s.evt_mask & ~wdata_i;
        EVT_MASK_OR:  n.evt_mask = s.evt_mask | wdata_i;
        IRQ_MASK:     n.irq_mask = wdata_i;
        IRQ_MASK_AND: n.irq_mask = s.irq_mask & ~wdata_i;
        IRQ_MASK_OR:  n.irq_mask = s.irq_mask | wdata_i;
        BUFFER_CLEAR: clr = wdata_i;
        default: ;
      endcase
    end
    if (irq_ack_i[c]) begin
      clr[irq_ack_id_i[c]] = 1'b1;
    end
    if (wait_req_i[c] && wait_clear_i[c] && masked != '0) begin
      clr |= masked;
    end
    n.buffer  = (s.buffer & ~clr) | event_lines_i[c] | sw;
    n.irq_req = (imasked != '0);
    if (!s.sleep) begin
      n.sleep = wait_req_i[c] && masked == '0 && imasked == '0;
    end else begin
      n.sleep = (masked == '0) && (imasked == '0);
    end
    return n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // model steps on the rising edge and outputs are compared once settled
  always begin : compare_outputs
    @(posedge clk_i);
    if (!rst_ni) begin
      for (int c = 0; c < NB; c++) begin
        mdl[c] = '0;
      end
    end else begin
      exp_rvalid = req_i && !we_i;
      exp_rdata  = exp_rvalid ? ref_read(mdl[addr_i.core], addr_i.reg_off) : '0;
      for (int c = 0; c < NB; c++) begin
        mdl[c] = ref_core(mdl[c], c);
      end
      #1;
      compare_value("gnt", 32'(req_i), 32'(gnt_o));
      compare_value("rvalid", 32'(exp_rvalid), 32'(rvalid_o));
      compare_value("rdata", exp_rdata, rdata_o);
      for (int c = 0; c < NB; c++) begin
        compare_value($sformatf("clock_en[%0d]", c), 32'(!mdl[c].sleep), 32'(clock_en_o[c]));
        compare_value($sformatf("irq_req[%0d]", c), 32'(mdl[c].irq_req), 32'(irq_req_o[c]));
        compare_value($sformatf("irq_id[%0d]", c),
                      32'(top_index(mdl[c].buffer & mdl[c].irq_mask)), 32'(irq_id_o[c]));
        compare_value($sformatf("wake[%0d]", c),
                      32'(wait_req_i[c] && (mdl[c].buffer & mdl[c].evt_mask) != '0),
                      32'(wake_o[c]));
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout: run did not end within %0d cycles", TIMEOUT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic drive_bus(input logic we, input core_idx_t core, input eu_reg_e off,
                           input event_vec_t data);
    req_i           = 1'b1;
    we_i            = we;
    addr_i.core     = core;
    addr_i.reg_off  = off;
    addr_i.byte_off = 2'b00;
    wdata_i         = data;
  endtask

  task automatic idle_bus();
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
  endtask

  // one random bus operation per cycle with the mode selecting the register group
  task automatic run_random(input int n, input int mode);
    logic [31:0] r;
    core_idx_t   core;
    event_vec_t  data;
    repeat (n) begin
      @(negedge clk_i);
      r    = next_rand();
      core = core_idx_t'(r[9:8]);
      for (int c = 0; c < NB; c++) begin
        // sparse lines with about one bit in eight set
        event_lines_i[c] = (mode == MODE_BUF) ? (next_rand() & next_rand() & next_rand()) : '0;
      end
      case (mode)
        MODE_MASK: begin
          if (!r[1]) begin
            drive_bus(1'b1, core, eu_reg_e'(4'(r[15:8] % 6)), next_rand());
          end else if (r[2]) begin
            drive_bus(1'b0, core, EVT_MASK, '0);
          end else begin
            drive_bus(1'b0, core, IRQ_MASK, '0);
          end
        end
        MODE_BUF: begin
          if (r[1:0] == 2'd0) begin
            drive_bus(1'b1, core, BUFFER_CLEAR, next_rand());
          end else if (r[1:0] == 2'd1) begin
            drive_bus(1'b1, core, eu_reg_e'(4'(r[15:8] % 6)), next_rand());
          end else begin
            drive_bus(1'b0, core, eu_reg_e'(4'(7 + r[15:8] % 3)), '0);
          end
        end
        default: begin
          data = next_rand() & 32'h000f_00ff;
          // a quarter of the triggers go to all cores via a zero mask
          if (r[4:3] == 2'b00) begin
            data[19:16] = '0;
          end
          if (!r[1]) begin
            drive_bus(1'b1, core, SW_TRIGGER, data);
          end else if (r[0]) begin
            drive_bus(1'b0, core, BUFFER, '0);
          end else begin
            drive_bus(1'b1, core, BUFFER_CLEAR, '1);
          end
        end
      endcase
    end
  endtask

  task automatic run_irq_test();
    for (int c = 0; c < NB; c++) begin
      @(negedge clk_i);
      drive_bus(1'b1, core_idx_t'(c), IRQ_MASK, next_rand() | 32'h8000_0001);
    end
    for (int i = 0; i < N_IRQ; i++) begin
      @(negedge clk_i);
      idle_bus();
      for (int c = 0; c < NB; c++) begin
        // serve the reported id while a request is up
        irq_ack_i[c]     = irq_req_o[c];
        irq_ack_id_i[c]  = irq_id_o[c];
        event_lines_i[c] = (i < 20) ? (next_rand() & next_rand() & next_rand()) : '0;
      end
    end
    @(negedge clk_i);
    irq_ack_i = '0;
  endtask

  task automatic run_sleep_test(input int c);
    event_vec_t mask;
    mask = next_rand() | 32'h0000_0100;
    @(negedge clk_i);
    drive_bus(1'b1, core_idx_t'(c), EVT_MASK, mask);
    @(negedge clk_i);
    drive_bus(1'b1, core_idx_t'(c), IRQ_MASK, '0);
    @(negedge clk_i);
    drive_bus(1'b1, core_idx_t'(c), BUFFER_CLEAR, '1);
    @(negedge clk_i);
    idle_bus();
    wait_req_i[c]   = 1'b1;
    wait_clear_i[c] = 1'b1;
    do begin
      @(negedge clk_i);
    end while (clock_en_o[c]);
    drive_bus(1'b0, core_idx_t'(c), CLOCK_STATUS, '0);
    repeat (3) begin
      @(negedge clk_i);
      idle_bus();
    end
    // lowest masked bit as the wake event
    event_lines_i[c] = mask & (~mask + 1);
    @(negedge clk_i);
    event_lines_i[c] = '0;
    do begin
      @(negedge clk_i);
    end while (!clock_en_o[c]);
    drive_bus(1'b0, core_idx_t'(c), BUFFER_MASKED, '0);
    wait_req_i[c]   = 1'b0;
    wait_clear_i[c] = 1'b0;
    @(negedge clk_i);
    idle_bus();
  endtask

  initial begin : stimulus
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    rng_state    = 32'he72072bd;
    irq_ack_i    = '0;
    wait_req_i   = '0;
    wait_clear_i = '0;
    idle_bus();
    for (int c = 0; c < NB; c++) begin
      event_lines_i[c] = '0;
      irq_ack_id_i[c]  = '0;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    run_random(N_MASK, MODE_MASK);
    run_random(N_BUF, MODE_BUF);
    run_random(N_TRIG, MODE_TRIG);
    run_irq_test();
    for (int c = 0; c < NB; c++) begin
      run_sleep_test(c);
    end
    repeat (4) @(negedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: test/eu_props.sv
//**************************************************************************
// bus handshake and wake timing assertions bound into the event unit top
//**************************************************************************

`timescale 1ns/10ps

`include "eu_macros.svh"

module eu_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    req_i,
  input logic                    we_i,
  input logic                    gnt_o,
  input logic                    rvalid_o,
  input logic [`EU_NB_CORES-1:0] wake_o,
  input logic [`EU_NB_CORES-1:0] clock_en_o
);

  logic rd_req;

  assign rd_req = req_i & ~we_i;

  gnt_equals_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o == req_i)
    else $error("gnt_o differs from req_i");

  // a read is answered exactly one cycle later
  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req |=> rvalid_o)
    else $error("rvalid_o missing one cycle after a read");

  no_rvalid_without_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_req |=> !rvalid_o)
    else $error("rvalid_o high without a read one cycle earlier");

  // a wake seen while the core sleeps ungates its clock at the next edge
  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_wake
    wake_restores_clock: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wake_o[c] && !clock_en_o[c] |=> clock_en_o[c])
      else $error("clock_en_o still low one cycle after wake_o on core %0d", c);
  end

endmodule

bind event_unit eu_props props_inst (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (req_i),
  .we_i       (we_i),
  .gnt_o      (gnt_o),
  .rvalid_o   (rvalid_o),
  .wake_o     (wake_o),
  .clock_en_o (clock_en_o)
);

// File: rtl/event_unit.sv
//**************************************************************************
// event unit top: bus decoder, per-core slices and read mux
//**************************************************************************

`timescale 1ns/10ps

`include "eu_macros.svh"

module event_unit
  import eu_reg_pkg::*;
  import eu_core_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // register bus
  input  logic                    req_i,
  input  logic                    we_i,
  input  eu_addr_t                addr_i,
  input  event_vec_t              wdata_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output event_vec_t              rdata_o,
  // core side
  input  event_vec_t              event_lines_i [`EU_NB_CORES],
  input  logic [`EU_NB_CORES-1:0] irq_ack_i,
  input  irq_id_t                 irq_ack_id_i  [`EU_NB_CORES],
  input  logic [`EU_NB_CORES-1:0] wait_req_i,
  input  logic [`EU_NB_CORES-1:0] wait_clear_i,
  output logic [`EU_NB_CORES-1:0] irq_req_o,
  output irq_id_t                 irq_id_o      [`EU_NB_CORES],
  output logic [`EU_NB_CORES-1:0] wake_o,
  output logic [`EU_NB_CORES-1:0] clock_en_o
);

  eu_slice_wr_if wr_if [`EU_NB_CORES] ();
  eu_slice_rd_if rd_if [`EU_NB_CORES] ();

  // no back-pressure on the bus
  assign gnt_o = req_i;

  eu_bus_decoder i_decoder (
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .wr_o    (wr_if)
  );

  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_core
    eu_core_slice i_slice (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .wr_i          (wr_if[c]),
      .rd_o          (rd_if[c]),
      .event_lines_i (event_lines_i[c]),
      .irq_ack_i     (irq_ack_i[c]),
      .irq_ack_id_i  (irq_ack_id_i[c]),
      .wait_req_i    (wait_req_i[c]),
      .wait_clear_i  (wait_clear_i[c]),
      .irq_req_o     (irq_req_o[c]),
      .irq_id_o      (irq_id_o[c]),
      .wake_o        (wake_o[c]),
      .clock_en_o    (clock_en_o[c])
    );
  end

  eu_read_mux i_read_mux (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .rd_i     (rd_if),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

endmodule

// File: rtl/eu_read_mux.sv
//**************************************************************************
// read path: register select across slices and registered response
//**************************************************************************

`timescale 1ns/10ps

`include "eu_macros.svh"

module eu_read_mux
  import eu_reg_pkg::*;
  import eu_core_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  input  eu_addr_t   addr_i,
  eu_slice_rd_if.mux rd_i [`EU_NB_CORES],
  output logic       rvalid_o,
  output event_vec_t rdata_o
);

  event_vec_t              evt_mask_a [`EU_NB_CORES];
  event_vec_t              irq_mask_a [`EU_NB_CORES];
  event_vec_t              buffer_a   [`EU_NB_CORES];
  logic [`EU_NB_CORES-1:0] clock_en_a;

  logic       rd_req;
  event_vec_t rd_data;
  logic       rvalid_q;
  event_vec_t rdata_q;

  // flatten the interface array so the core index can select dynamically
  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_gather
    assign evt_mask_a[c] = rd_i[c].evt_mask;
    assign irq_mask_a[c] = rd_i[c].irq_mask;
    assign buffer_a[c]   = rd_i[c].buffer;
    assign clock_en_a[c] = rd_i[c].clock_en;
  end

  assign rd_req = req_i & ~we_i;

  always_comb begin
    rd_data = '0;
    case (addr_i.reg_off)
      EVT_MASK:          rd_data = evt_mask_a[addr_i.core];
      IRQ_MASK:          rd_data = irq_mask_a[addr_i.core];
      CLOCK_STATUS:      rd_data[0] = clock_en_a[addr_i.core];
      BUFFER:            rd_data = buffer_a[addr_i.core];
      BUFFER_MASKED:     rd_data = buffer_a[addr_i.core] & evt_mask_a[addr_i.core];
      BUFFER_IRQ_MASKED: rd_data = buffer_a[addr_i.core] & irq_mask_a[addr_i.core];
      // write-only and unmapped offsets read as zero
      default: ;
    endcase
  end

  // one response slot per cycle, data is zero outside a response
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= rd_req;
      rdata_q  <= rd_req ? rd_data : '0;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: rtl/eu_core_slice.sv
//**************************************************************************
// per-core slice: masks, event buffer, interrupt request, sleep control
//**************************************************************************

`timescale 1ns/10ps

`include "eu_macros.svh"

module eu_core_slice
  import eu_reg_pkg::*;
  import eu_core_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  eu_slice_wr_if.slice wr_i,
  eu_slice_rd_if.slice rd_o,
  input  event_vec_t   event_lines_i,
  input  logic         irq_ack_i,
  input  irq_id_t      irq_ack_id_i,
  input  logic         wait_req_i,
  input  logic         wait_clear_i,
  output logic         irq_req_o,
  output irq_id_t      irq_id_o,
  output logic         wake_o,
  output logic         clock_en_o
);

  event_vec_t   evt_mask_q, evt_mask_d;
  event_vec_t   irq_mask_q, irq_mask_d;
  event_vec_t   buffer_q, buffer_d;
  logic         irq_req_q;
  sleep_state_e state_q, state_d;

  event_vec_t   evt_masked, irq_masked;
  event_vec_t   wr_clr, ack_clr, wake_clr;
  logic         evt_pending, irq_pending;

  assign evt_masked  = buffer_q & evt_mask_q;
  assign irq_masked  = buffer_q & irq_mask_q;
  assign evt_pending = |evt_masked;
  assign irq_pending = |irq_masked;

  // register writes: plain set, AND-clear, OR-set
  always_comb begin
    evt_mask_d = evt_mask_q;
    irq_mask_d = irq_mask_q;
    wr_clr     = '0;

    if (wr_i.wr_en) begin
      case (wr_i.wr_reg)
        EVT_MASK:     evt_mask_d = wr_i.wr_data;
        EVT_MASK_AND: evt_mask_d = evt_mask_q & ~wr_i.wr_data;
        EVT_MASK_OR:  evt_mask_d = evt_mask_q | wr_i.wr_data;
        IRQ_MASK:     irq_mask_d = wr_i.wr_data;
        IRQ_MASK_AND: irq_mask_d = irq_mask_q & ~wr_i.wr_data;
        IRQ_MASK_OR:  irq_mask_d = irq_mask_q | wr_i.wr_data;
        BUFFER_CLEAR: wr_clr     = wr_i.wr_data;
        default: ;
      endcase
    end
  end

  // wake fires while the core waits and a masked event is pending
  assign wake_o   = wait_req_i & evt_pending;
  assign wake_clr = (wake_o && wait_clear_i) ? evt_masked : '0;
  assign ack_clr  = irq_ack_i ? (event_vec_t'(1) << irq_ack_id_i) : '0;

  // new events take precedence over clears in the same cycle
  assign buffer_d = (buffer_q & ~(wr_clr | ack_clr | wake_clr))
                  | event_lines_i | wr_i.sw_set;

  // highest set index wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < `EU_EVT_W; i++) begin
      if (irq_masked[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ACTIVE: begin
        if (wait_req_i && !evt_pending && !irq_pending) begin
          state_d = SLEEP;
        end
      end
      SLEEP: begin
        // an interrupt wakes the core just like a masked event
        if (evt_pending || irq_pending) begin
          state_d = ACTIVE;
        end
      end
      default: state_d = ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q <= '0;
      irq_mask_q <= '0;
      buffer_q   <= '0;
      irq_req_q  <= 1'b0;
      state_q    <= ACTIVE;
    end else begin
      evt_mask_q <= evt_mask_d;
      irq_mask_q <= irq_mask_d;
      buffer_q   <= buffer_d;
      irq_req_q  <= irq_pending;
      state_q    <= state_d;
    end
  end

  assign irq_req_o  = irq_req_q;
  assign clock_en_o = (state_q == ACTIVE);

  assign rd_o.evt_mask = evt_mask_q;
  assign rd_o.irq_mask = irq_mask_q;
  assign rd_o.buffer   = buffer_q;
  assign rd_o.clock_en = clock_en_o;

endmodule

// File: rtl/eu_bus_decoder.sv
//**************************************************************************
// bus write decoder: per-slice write strobes and sw event broadcast
//**************************************************************************

`timescale 1ns/10ps

`include "eu_macros.svh"

module eu_bus_decoder
  import eu_reg_pkg::*;
  import eu_core_pkg::*;
(
  input  logic           req_i,
  input  logic           we_i,
  input  eu_addr_t       addr_i,
  input  event_vec_t     wdata_i,
  eu_slice_wr_if.decoder wr_o [`EU_NB_CORES]
);

  logic                    wr_access;
  logic                    is_trigger;
  logic [`EU_NB_CORES-1:0] trig_field;
  logic [`EU_NB_CORES-1:0] trig_cores;
  event_vec_t              sw_vec;

  assign wr_access  = req_i & we_i;
  // sw trigger goes to cores by mask, core field of the address is ignored
  assign is_trigger = wr_access && (addr_i.reg_off == SW_TRIGGER);

  assign trig_field = wdata_i[SW_TRIG_CORE_LSB +: `EU_NB_CORES];

  always_comb begin
    sw_vec = '0;
    sw_vec[`EU_NB_SW_EVT-1:0] = wdata_i[`EU_NB_SW_EVT-1:0];

    // all-zero target mask broadcasts to every core
    if (trig_field == '0) begin
      trig_cores = '1;
    end else begin
      trig_cores = trig_field;
    end
  end

  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : g_slice_wr
    logic core_hit;

    assign core_hit = (addr_i.core == core_idx_t'(c));

    // regular register writes only reach the addressed core
    assign wr_o[c].wr_en   = wr_access & ~is_trigger & core_hit;
    assign wr_o[c].wr_reg  = addr_i.reg_off;
    assign wr_o[c].wr_data = wdata_i;
    assign wr_o[c].sw_set  = (is_trigger && trig_cores[c]) ? sw_vec : '0;
  end

endmodule

// File: rtl/eu_ifs.sv
//**************************************************************************
// per-slice write and read interfaces between decoder, slices and read mux
//**************************************************************************

`timescale 1ns/10ps

// write side, decoder to one core slice
interface eu_slice_wr_if
  import eu_reg_pkg::*;
  import eu_core_pkg::*;
();

  logic       wr_en;
  eu_reg_e    wr_reg;
  event_vec_t wr_data;
  // software events hitting this core in the current cycle
  event_vec_t sw_set;

  modport decoder (
    output wr_en,
    output wr_reg,
    output wr_data,
    output sw_set
  );

  modport slice (
    input wr_en,
    input wr_reg,
    input wr_data,
    input sw_set
  );

endinterface

// read side, slice state exported to the read mux
interface eu_slice_rd_if
  import eu_core_pkg::*;
();

  event_vec_t evt_mask;
  event_vec_t irq_mask;
  event_vec_t buffer;
  logic       clock_en;

  modport slice (
    output evt_mask,
    output irq_mask,
    output buffer,
    output clock_en
  );

  modport mux (
    input evt_mask,
    input irq_mask,
    input buffer,
    input clock_en
  );

endinterface

// File: rtl/eu_core_pkg.sv
//**************************************************************************
// core side types: event vectors, interrupt ids, sleep states
//**************************************************************************

`include "eu_macros.svh"

package eu_core_pkg;

  // one bit per event line or buffer entry
  typedef logic [`EU_EVT_W-1:0] event_vec_t;

  // index of an event, used as interrupt id
  typedef logic [$clog2(`EU_EVT_W)-1:0] irq_id_t;

  // core clock gating states
  typedef enum logic {
    ACTIVE = 1'b0,
    SLEEP  = 1'b1
  } sleep_state_e;

endpackage

// File: rtl/eu_reg_pkg.sv
//**************************************************************************
// register map of the event unit bus: offsets and address fields
//**************************************************************************

`include "eu_macros.svh"

package eu_reg_pkg;

  // core select field of the bus address
  typedef logic [$clog2(`EU_NB_CORES)-1:0] core_idx_t;

  // word offsets inside a core's register window
  typedef enum logic [3:0] {
    EVT_MASK          = 4'd0,
    EVT_MASK_AND      = 4'd1,
    EVT_MASK_OR       = 4'd2,
    IRQ_MASK          = 4'd3,
    IRQ_MASK_AND      = 4'd4,
    IRQ_MASK_OR       = 4'd5,
    CLOCK_STATUS      = 4'd6,
    BUFFER            = 4'd7,
    BUFFER_MASKED     = 4'd8,
    BUFFER_IRQ_MASKED = 4'd9,
    BUFFER_CLEAR      = 4'd10,
    SW_TRIGGER        = 4'd14
  } eu_reg_e;

  // byte address, word aligned
  typedef struct packed {
    core_idx_t  core;
    eu_reg_e    reg_off;
    logic [1:0] byte_off;
  } eu_addr_t;

  // target core mask position in a sw trigger write
  localparam int unsigned SW_TRIG_CORE_LSB = 16;

endpackage

// File: include/eu_macros.svh
//**************************************************************************
// global sizing constants for the multi-core event unit
//**************************************************************************

`ifndef EU_MACROS_SVH
`define EU_MACROS_SVH

// number of cores served, one slice each
`define EU_NB_CORES 4

// event lines and buffer width per core
`define EU_EVT_W 32

// software events sit in the low buffer bits
`define EU_NB_SW_EVT 8

`endif
